/* icache_pkg.sv */
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // line geometry
    //////////////////////////////////////////////////////////////////////

    localparam int offset_bits = 2;                 // word offset bits in a line
    localparam int line_w      = 1 << offset_bits;  // words per line

    //////////////////////////////////////////////////////////////////////
    // pipeline side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_init    = 2'd0,  // index-init, way taken from the address
        op_idx_inv = 2'd1,  // index-invalidate
        op_hit_inv = 2'd2,  // invalidate only on a tag hit
        op_ibar    = 2'd3   // barrier, arrays untouched
    } cache_op_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        is_op;     // cache op instead of a fetch
        logic        uncached;  // bypass, never fills
        cache_op_t   op;
    } fetch_req_t;

    // stall sits in bit 0, flush in bit 1
    typedef struct packed {
        logic flush;
        logic stall;
    } pipe_ctrl_t;

    //////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;  // line aligned
        logic        req;
    } mem_req_t;

endpackage

/* icache_req_buf.sv */
`timescale 1ns/100ps

module icache_req_buf #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int tag_width    = 30 - index_width - offset_width
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    we,
    input  icache_pkg::fetch_req_t  req_in,
    output icache_pkg::fetch_req_t  req_q,
    output logic [tag_width-1:0]    tag,
    output logic [index_width-1:0]  index,
    output logic [offset_width-1:0] offset
);

    localparam int idx_lo = 2 + offset_width;   // bits [1:0] are the byte offset
    localparam int tag_lo = idx_lo + index_width;

    // request kind flags
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q.is_op    <= 1'b0;
            req_q.uncached <= 1'b0;
        end else if (we) begin
            req_q.is_op    <= req_in.is_op;
            req_q.uncached <= req_in.uncached;
        end
    end

    // address and op code
    always_ff @(posedge clk) begin
        if (we) begin
            req_q.addr <= req_in.addr;
            req_q.op   <= req_in.op;
        end
    end

    assign offset = req_q.addr[idx_lo-1:2];        // word within the line
    assign index  = req_q.addr[tag_lo-1:idx_lo];
    assign tag    = req_q.addr[31:tag_lo];

endmodule

/* icache_tagv.sv */
`timescale 1ns/100ps

module icache_tagv #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int tag_width    = 30 - index_width - offset_width,
    localparam int sets         = 1 << index_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   tag,
    output logic [1:0]             hit,
    input  logic [1:0]             fill_we,
    input  logic [1:0]             inv,
    input  logic                   init_en,
    input  logic                   init_way,
    input  logic [index_width-1:0] wr_index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim
);

    logic [tag_width-1:0]   tag_arr [2][sets];
    logic [sets-1:0]        valid [2];
    logic [sets-1:0]        lru;          // way to replace next, per set
    logic [index_width-1:0] rd_index_q;

    // registered read address, the flop arrays then show same-edge writes
    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
    end

    //////////////////////////////////////////////////////////////////////
    // valid and lru updates
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '{default: '0};
            lru   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (fill_we[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end else if (inv[w] || (init_en && w == int'(init_way))) begin
                    valid[w][wr_index] <= 1'b0;
                end
            end
            if (use0) begin
                lru[wr_index] <= 1'b1;    // way 0 just used
            end else if (use1) begin
                lru[wr_index] <= 1'b0;
            end
        end
    end

    // tags, init also wipes the tag
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (fill_we[w]) begin
                tag_arr[w][wr_index] <= tag;
            end else if (init_en && w == int'(init_way)) begin
                tag_arr[w][wr_index] <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid[w][rd_index_q] && (tag_arr[w][rd_index_q] == tag);
        end
    end

    assign victim = lru[wr_index];

endmodule

/* icache_data.sv */
`timescale 1ns/100ps

module icache_data #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int sets         = 1 << index_width,
    localparam int line_bits    = 32 * icache_pkg::line_w
) (
    input  logic                    clk,
    input  logic [index_width-1:0]  rd_index,
    input  logic [index_width-1:0]  wr_index,
    input  logic [1:0]              we,
    input  logic [line_bits-1:0]    line_in,
    input  logic                    choose_way,
    input  logic                    choose_return,
    input  logic [offset_width-1:0] word_sel,
    output logic [31:0]             inst
);

    logic [line_bits-1:0] mem [2][sets];
    logic [line_bits-1:0] line_q [2];    // read port, one per way
    logic [line_bits-1:0] line_sel;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we[w]) begin
                mem[w][wr_index] <= line_in;
            end
            // write-first, a request taken on the fill edge reads the new line
            if (we[w] && wr_index == rd_index) begin
                line_q[w] <= line_in;
            end else begin
                line_q[w] <= mem[w][rd_index];
            end
        end
    end

    assign line_sel = choose_return ? line_in : line_q[choose_way];  // refill bypass
    assign inst     = line_sel[32*word_sel +: 32];

endmodule

/* icache_fsm.sv */
`timescale 1ns/100ps

module icache_fsm #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   valid,
    input  icache_pkg::pipe_ctrl_t ctrl,
    output logic                   ready,
    input  icache_pkg::fetch_req_t req_q,
    input  logic [1:0]             hit,
    input  logic                   victim,
    input  logic                   addr_ok,
    input  logic                   data_ok,
    output logic                   mem_req_o,
    output logic                   buf_we,
    output logic [1:0]             data_we,
    output logic [1:0]             inv,
    output logic                   use0,
    output logic                   use1,
    output logic                   init_en,
    output logic                   init_way,
    output logic                   choose_way,
    output logic                   choose_return,
    output logic                   inst_valid
);

    import icache_pkg::*;

    // index ops pick the way with the lowest tag bit
    localparam int way_bit = 2 + offset_width + index_width;

    typedef enum logic [2:0] {
        s_idle, s_lookup, s_miss_req, s_miss_wait, s_operation, s_flush
    } state_t;

    state_t     state;
    state_t     next_state;
    state_t     cur;          // decoded state
    logic       rstn_q;
    logic       shown;        // hit already answered, held by stall
    logic       ready_int;
    logic       accept;
    logic       miss;
    logic [1:0] hit_one;

    assign ready   = ready_int & rstn_q;     // no ready in the first cycle out of reset
    assign accept  = valid & ready;
    assign buf_we  = accept;
    assign hit_one = hit[0] ? 2'b01 : {hit[1], 1'b0};
    assign miss    = !(|hit) || req_q.uncached;

    // every accept lands in lookup, the buffered request tells op from fetch
    assign cur = (state == s_lookup && req_q.is_op) ? s_operation : state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= s_idle;
            rstn_q <= 1'b0;
            shown  <= 1'b0;
        end else begin
            state  <= next_state;
            rstn_q <= 1'b1;
            if (accept) begin
                shown <= 1'b0;
            end else if (inst_valid) begin
                shown <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = s_idle;
        unique case (cur)
            s_idle, s_flush: next_state = accept ? s_lookup : cur;
            s_lookup: begin
                if (ctrl.flush) begin
                    next_state = accept ? s_lookup : s_flush;
                end else if (miss) begin
                    next_state = addr_ok ? s_miss_wait : s_miss_req;  // fast handshake
                end else if (ctrl.stall) begin
                    next_state = s_lookup;
                end else begin
                    next_state = accept ? s_lookup : s_idle;
                end
            end
            s_operation: next_state = accept ? s_lookup : (ctrl.flush ? s_flush : s_idle);
            s_miss_req:  next_state = addr_ok ? s_miss_wait : s_miss_req;
            s_miss_wait: begin
                if (!data_ok) begin
                    next_state = s_miss_wait;
                end else begin
                    next_state = accept ? s_lookup : s_idle;
                end
            end
            default: next_state = s_idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ready_int     = 1'b0;
        mem_req_o     = 1'b0;
        data_we       = 2'b00;
        inv           = 2'b00;
        use0          = 1'b0;
        use1          = 1'b0;
        init_en       = 1'b0;
        init_way      = req_q.addr[way_bit];
        choose_way    = hit_one[1];
        choose_return = 1'b0;
        inst_valid    = 1'b0;
        unique case (cur)
            s_idle, s_flush: ready_int = 1'b1;
            s_lookup: begin
                if (ctrl.flush) begin
                    ready_int = 1'b1;                    // request dropped
                end else if (miss) begin
                    mem_req_o = 1'b1;
                    if (req_q.uncached) inv = hit_one;   // drop a cached copy
                end else begin
                    ready_int  = !ctrl.stall;
                    inst_valid = !shown;
                    use0       = !shown && hit[0];
                    use1       = !shown && !hit[0];
                end
            end
            s_operation: begin
                ready_int = 1'b1;
                if (!ctrl.flush) begin
                    unique case (req_q.op)
                        op_init:    init_en = 1'b1;
                        op_idx_inv: inv[req_q.addr[way_bit]] = 1'b1;
                        op_hit_inv: inv = hit_one;
                        default:    ;                   // ibar
                    endcase
                end
            end
            s_miss_req: mem_req_o = 1'b1;
            s_miss_wait: begin
                if (data_ok) begin
                    ready_int     = 1'b1;
                    inst_valid    = 1'b1;
                    choose_return = 1'b1;
                    if (!req_q.uncached) begin
                        data_we[victim] = 1'b1;          // fill the lru way
                        use0            = !victim;
                        use1            = victim;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* icache_top.sv */
`timescale 1ns/100ps

module icache_top #(
    parameter int  index_width  = 4,
    parameter int  offset_width = icache_pkg::offset_bits,
    localparam int tag_width    = 30 - index_width - offset_width
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            valid,
    input  icache_pkg::fetch_req_t          req,
    input  icache_pkg::pipe_ctrl_t          ctrl,
    output logic                            ready,
    output logic                            inst_valid,
    output logic [31:0]                     inst,
    output icache_pkg::mem_req_t            mem_req,
    input  logic                            addr_ok,
    input  logic                            data_ok,
    input  logic [32*icache_pkg::line_w-1:0] mem_line
);

    import icache_pkg::*;

    localparam int idx_lo = 2 + offset_width;

    fetch_req_t              req_q;
    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [index_width-1:0]  rd_index;
    logic [offset_width-1:0] offset;
    logic [1:0]              hit;
    logic [1:0]              data_we;
    logic [1:0]              inv;
    logic                    buf_we;
    logic                    mem_req_o;
    logic                    victim;
    logic                    use0;
    logic                    use1;
    logic                    init_en;
    logic                    init_way;
    logic                    choose_way;
    logic                    choose_return;

    // incoming index on the accept edge, buffered one otherwise
    assign rd_index     = buf_we ? req.addr[idx_lo +: index_width] : index;
    assign mem_req.addr = {req_q.addr[31:idx_lo], {idx_lo{1'b0}}};
    assign mem_req.req  = mem_req_o;

    icache_req_buf #(.index_width(index_width), .offset_width(offset_width)) i_req_buf (
        .clk    (clk),
        .rstn   (rstn),
        .we     (buf_we),
        .req_in (req),
        .req_q  (req_q),
        .tag    (tag),
        .index  (index),
        .offset (offset)
    );

    icache_tagv #(.index_width(index_width), .offset_width(offset_width)) i_tagv (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .tag      (tag),
        .hit      (hit),
        .fill_we  (data_we),     // tag and line written together
        .inv      (inv),
        .init_en  (init_en),
        .init_way (init_way),
        .wr_index (index),
        .use0     (use0),
        .use1     (use1),
        .victim   (victim)
    );

    icache_data #(.index_width(index_width), .offset_width(offset_width)) i_data (
        .clk           (clk),
        .rd_index      (rd_index),
        .wr_index      (index),
        .we            (data_we),
        .line_in       (mem_line),
        .choose_way    (choose_way),
        .choose_return (choose_return),
        .word_sel      (offset),
        .inst          (inst)
    );

    icache_fsm #(.index_width(index_width), .offset_width(offset_width)) i_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .valid         (valid),
        .ctrl          (ctrl),
        .ready         (ready),
        .req_q         (req_q),
        .hit           (hit),
        .victim        (victim),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .mem_req_o     (mem_req_o),
        .buf_we        (buf_we),
        .data_we       (data_we),
        .inv           (inv),
        .use0          (use0),
        .use1          (use1),
        .init_en       (init_en),
        .init_way      (init_way),
        .choose_way    (choose_way),
        .choose_return (choose_return),
        .inst_valid    (inst_valid)
    );

endmodule

/* icache_checker.sv */
`timescale 1ns/100ps

module icache_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 valid,
    input logic                 ready,
    input logic                 inst_valid,
    input icache_pkg::mem_req_t mem_req,
    input logic                 addr_ok
);

    logic accepted;    // a request was taken since reset

    always_ff @(posedge clk) begin
        if (!rstn) begin
            accepted <= 1'b0;
        end else if (valid && ready) begin
            accepted <= 1'b1;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req.req && !addr_ok |=> mem_req.req)
        else $error("mem_req dropped before addr_ok");

    inst_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid |-> accepted)
        else $error("inst_valid without any accepted request");

    ready_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> !ready)
        else $error("ready high in the first cycle after reset");

endmodule

bind icache_top icache_checker i_checker (
    .clk        (clk),
    .rstn       (rstn),
    .valid      (valid),
    .ready      (ready),
    .inst_valid (inst_valid),
    .mem_req    (mem_req),
    .addr_ok    (addr_ok)
);

/* tb_icache_monitor.sv */
`timescale 1ns/100ps

module tb_icache_monitor #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input logic                   clk,
    input logic                   rstn,
    input logic                   valid,
    input logic                   ready,
    input icache_pkg::fetch_req_t req,
    input icache_pkg::pipe_ctrl_t ctrl,
    input logic                   inst_valid,
    input logic [31:0]            inst,
    input icache_pkg::mem_req_t   mem_req,
    input logic                   addr_ok,
    input logic                   data_ok
);

    import icache_pkg::*;

    localparam int idx_lo   = 2 + offset_width;
    localparam int tag_lo   = idx_lo + index_width;
    localparam int way_bit  = tag_lo;         // index ops take the way from here
    localparam int sets     = 1 << index_width;
    localparam int max_wait = 200;

    // reference cache
    logic [31-tag_lo:0] m_tag [2][sets];
    logic [sets-1:0]    m_valid [2];
    logic [sets-1:0]    m_lru;              // way to replace next

    fetch_req_t  cur;
    logic        busy = 1'b0;
    logic        exp_hit;
    logic [31:0] exp_line;
    int          cycles;
    int          handshakes;
    int          errs_before;
    int          test_count  = 0;
    int          error_count = 0;

    function automatic logic [31:0] word_of(logic [31:0] a);
        return a * 32'h9e37_79b9;
    endfunction

    function automatic int find_way(logic [31:0] a);
        int idx;
        idx = int'(a[tag_lo-1:idx_lo]);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == a[31:tag_lo]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic string kind_name(fetch_req_t r);
        if (r.is_op) return r.op.name();
        return r.uncached ? "uncached fetch" : "fetch";
    endfunction

    task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic complain(string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic close_test(string note);
        $display("test %0d: %s %h%s %s", test_count, kind_name(cur), cur.addr, note,
                 (error_count == errs_before) ? "ok" : "FAILED");
        test_count++;
        busy = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // model update once a request completes
    //////////////////////////////////////////////////////////////////////

    task automatic update_model();
        int idx;
        int way;
        int w;
        idx = int'(cur.addr[tag_lo-1:idx_lo]);
        way = find_way(cur.addr);
        if (cur.is_op) begin
            w = int'(cur.addr[way_bit]);
            case (cur.op)
                op_init, op_idx_inv: m_valid[w][idx] = 1'b0;
                op_hit_inv:          if (way >= 0) m_valid[way][idx] = 1'b0;
                default:             ;
            endcase
        end else if (cur.uncached) begin
            if (way >= 0) m_valid[way][idx] = 1'b0;   // cached copy dropped
        end else if (way >= 0) begin
            m_lru[idx] = (way == 0);
        end else begin
            w = int'(m_lru[idx]);
            m_valid[w][idx] = 1'b1;
            m_tag[w][idx]   = cur.addr[31:tag_lo];
            m_lru[idx]      = (w == 0);
        end
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            m_valid = '{default: '0};
            m_lru   = '0;
            busy    = 1'b0;
        end else begin
            if (mem_req.req && addr_ok && busy) begin
                handshakes++;
            end
            if (busy) begin
                cycles++;
                if (cycles == 1) begin
                    if (ctrl.flush || cur.is_op) begin
                        if (inst_valid) mismatch("inst_valid", 32'd0, 32'd1);
                        if (mem_req.req) mismatch("mem_req.req", 32'd0, 32'd1);
                        if (!ready) mismatch("ready", 32'd1, 32'd0);
                        if (!ctrl.flush) update_model();
                        close_test(ctrl.flush ? " flushed" : "");
                    end else if (exp_hit) begin
                        if (mem_req.req) mismatch("mem_req.req", 32'd0, 32'd1);
                        if (ready == ctrl.stall) begin
                            mismatch("ready", {31'd0, !ctrl.stall}, {31'd0, ready});
                        end
                        if (!inst_valid) begin
                            mismatch("inst_valid", 32'd1, 32'd0);
                        end else if (inst !== word_of(cur.addr)) begin
                            mismatch("inst", word_of(cur.addr), inst);
                        end
                        update_model();
                        close_test(" hit");
                    end else begin
                        if (ready) mismatch("ready", 32'd0, 32'd1);
                        if (!mem_req.req) mismatch("mem_req.req", 32'd1, 32'd0);
                        else if (mem_req.addr !== exp_line) begin
                            mismatch("mem_req.addr", exp_line, mem_req.addr);
                        end
                    end
                end else if (inst_valid) begin
                    if (inst !== word_of(cur.addr)) mismatch("inst", word_of(cur.addr), inst);
                    if (handshakes != 1) mismatch("mem handshakes", 32'd1, handshakes);
                    if (!data_ok) mismatch("data_ok", 32'd1, 32'd0);
                    if (!ready) mismatch("ready", 32'd1, 32'd0);
                    update_model();
                    close_test(" miss");
                end else if (cycles > max_wait) begin
                    complain("no inst_valid for a missed fetch");
                    close_test(" miss");
                end else if (ready) begin
                    mismatch("ready", 32'd0, 32'd1);
                end
            end else begin
                if (inst_valid) complain("inst_valid with no fetch outstanding");
                if (mem_req.req) complain("mem_req raised with no miss outstanding");
            end
            if (valid && ready) begin
                cur         = req;
                busy        = 1'b1;
                cycles      = 0;
                handshakes  = 0;
                errs_before = error_count;
                exp_hit     = !req.uncached && find_way(req.addr) >= 0;
                exp_line    = {req.addr[31:idx_lo], {idx_lo{1'b0}}};
            end
        end
    end

endmodule

/* tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

    import icache_pkg::*;

    localparam int index_width  = 4;
    localparam int offset_width = offset_bits;
    localparam int idx_lo       = 2 + offset_width;
    localparam int tag_lo       = idx_lo + index_width;
    localparam int n_tests      = 300;
    localparam int max_wait     = 200;

    logic                   clk;
    logic                   rstn;
    logic                   valid;
    fetch_req_t             req;
    pipe_ctrl_t             ctrl;
    logic                   ready;
    logic                   inst_valid;
    logic [31:0]            inst;
    mem_req_t               mem_req;
    logic                   addr_ok;
    logic                   data_ok;
    logic [32*line_w-1:0]   mem_line;
    int                     seed = 32'h675b_31a7;
    logic                   timed_out;

    icache_top #(.index_width(index_width), .offset_width(offset_width)) i_icache_top (
        .clk        (clk),
        .rstn       (rstn),
        .valid      (valid),
        .req        (req),
        .ctrl       (ctrl),
        .ready      (ready),
        .inst_valid (inst_valid),
        .inst       (inst),
        .mem_req    (mem_req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .mem_line   (mem_line)
    );

    tb_icache_monitor #(.index_width(index_width), .offset_width(offset_width)) i_monitor (
        .clk        (clk),
        .rstn       (rstn),
        .valid      (valid),
        .ready      (ready),
        .req        (req),
        .ctrl       (ctrl),
        .inst_valid (inst_valid),
        .inst       (inst),
        .mem_req    (mem_req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [32*line_w-1:0] build_line(logic [31:0] a);
        logic [32*line_w-1:0] l;
        for (int w = 0; w < line_w; w++) begin
            l[32*w +: 32] = (a + 32'(4 * w)) * 32'h9e37_79b9;
        end
        return l;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          gap;
        logic [31:0] line_addr;
        addr_ok  = 1'b0;
        data_ok  = 1'b0;
        mem_line = '0;
        forever begin
            @(negedge clk);
            if (mem_req.req && addr_ok) begin
                line_addr = mem_req.addr;
                gap       = {$random(seed)} % 3;
                @(posedge clk);
                addr_ok <= 1'b0;
                repeat (gap) @(posedge clk);
                data_ok  <= 1'b1;
                mem_line <= build_line(line_addr);
                @(posedge clk);
                data_ok <= 1'b0;
            end else begin
                @(posedge clk);
                addr_ok <= ({$random(seed)} % 3 == 0);   // early addr_ok now and then
            end
        end
    end

    // few tags over four sets, so conflicts and evictions show up
    task automatic pick_request(output fetch_req_t r, output logic fl, output logic st);
        int roll;
        roll       = {$random(seed)} % 100;
        r          = '0;
        r.addr[31:tag_lo]      = 24'h0003a0 + ({$random(seed)} % 5);
        r.addr[tag_lo-1:idx_lo] = {$random(seed)} % 4;
        r.addr[idx_lo-1:2]      = {$random(seed)} % line_w;
        r.uncached = (roll >= 60 && roll < 70);
        r.is_op    = (roll >= 70);
        r.op       = cache_op_t'({$random(seed)} % 4);
        fl         = ({$random(seed)} % 10 == 0);
        st         = ({$random(seed)} % 7 == 0);
    endtask

    task automatic send_request(input fetch_req_t r, input logic fl, input logic st);
        int n;
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ready && n < max_wait);
        if (!ready) begin
            $display("Timeout: request to %h was never accepted", r.addr);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        valid <= 1'b0;
        ctrl  <= {fl, st};       // seen in the lookup cycle
        @(posedge clk);
        ctrl <= '0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ready && n < max_wait);
        if (!ready) begin
            $display("Timeout: request to %h never completed", r.addr);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        fetch_req_t r;
        logic       fl;
        logic       st;
        valid     = 1'b0;
        req       = '0;
        ctrl      = '0;
        rstn      = 1'b0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < n_tests && !timed_out; i++) begin
            pick_request(r, fl, st);
            send_request(r, fl, st);
        end
        repeat (4) @(posedge clk);
        $display("tests: %0d, errors: %0d", i_monitor.test_count, i_monitor.error_count);
        if (timed_out || i_monitor.error_count != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

/* project.f */
icache_pkg.sv
icache_req_buf.sv
icache_tagv.sv
icache_data.sv
icache_fsm.sv
icache_top.sv
icache_checker.sv
tb_icache_monitor.sv
tb_icache.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_icache -o sim_icache \
    && ./obj_dir/sim_icache | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
